// ==== common/div_pkg.sv ====
// ========================================
// shared definitions for the divide unit
// width constants, opcode and state enums and a few
// opcode helpers; modules pull it in by wildcard import
// ========================================
package div_pkg;

  // ========================================
  // widths
  localparam int XLEN   = 64;  // operand and result width
  localparam int WORD_W = 32;  // width of the w variants
  localparam int CNT_W  = 7;   // holds 0 to 64

  // ========================================
  // opcodes
  // bit 2 picks remainder, bit 1 unsigned, bit 0 word
  typedef enum logic [2:0] {
    OP_DIV   = 3'b000,
    OP_DIVW  = 3'b001,
    OP_DIVU  = 3'b010,
    OP_DIVUW = 3'b011,
    OP_REM   = 3'b100,
    OP_REMW  = 3'b101,
    OP_REMU  = 3'b110,
    OP_REMUW = 3'b111
  } div_op_e;

  // iteration FSM of the core
  typedef enum logic [1:0] {
    IDLE = 2'b00,  // waiting for an operation
    RUN  = 2'b01,  // one quotient bit per cycle
    DONE = 2'b10   // result held for the output side
  } core_state_e;

  // ========================================
  // opcode field helpers
  function automatic logic op_is_rem(input div_op_e op);
    return op[2];
  endfunction

  function automatic logic op_is_unsigned(input div_op_e op);
    return op[1];
  endfunction

  function automatic logic op_is_word(input div_op_e op);
    return op[0];
  endfunction

  // sign-extend the low word to full width
  function automatic logic [XLEN-1:0] sext_word(input logic [XLEN-1:0] x);
    return {{(XLEN-WORD_W){x[WORD_W-1]}}, x[WORD_W-1:0]};
  endfunction

endpackage

// ==== div_core/div_restoring_core.sv ====
`timescale 1ns/1ns
// ========================================
// restoring shift-subtract divider with one quotient bit per cycle
// 64 steps for doubleword ops, 32 for word ops
// special ops pass straight through to DONE
// ========================================
module div_restoring_core
  import div_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            prep_valid_i,
  output logic            prep_ready_o,
  input  div_op_e         prep_op_i,
  input  logic [XLEN-1:0] prep_dividend_i,
  input  logic [XLEN-1:0] prep_divisor_i,
  input  logic            prep_neg_q_i,
  input  logic            prep_neg_r_i,
  input  logic            prep_special_i,
  input  logic [XLEN-1:0] prep_special_result_i,
  output logic            core_valid_o,
  input  logic            core_ready_i,
  output div_op_e         core_op_o,
  output logic [XLEN-1:0] core_quotient_o,
  output logic [XLEN-1:0] core_remainder_o,
  output logic            core_neg_q_o,
  output logic            core_neg_r_o,
  output logic            core_special_o,
  output logic [XLEN-1:0] core_special_result_o
);

  core_state_e       state_q;
  logic [CNT_W-1:0]  cnt_q;      // iterations left
  logic [2*XLEN-1:0] rq_q;       // {remainder, quotient}
  logic [XLEN-1:0]   dvs_q;
  logic [XLEN:0]     part;       // shifted remainder plus next bit
  logic [XLEN+1:0]   diff;
  logic              q_bit;
  logic              take;

  assign prep_ready_o = (state_q == IDLE);
  assign take         = prep_valid_i && prep_ready_o;

  // ========================================
  // one restoring step
  assign part  = rq_q[2*XLEN-1:XLEN-1];
  assign diff  = {1'b0, part} - {2'b0, dvs_q};
  assign q_bit = !diff[XLEN+1];  // no borrow

  // ========================================
  // FSM and counter
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (take) begin
            state_q <= prep_special_i ? DONE : RUN;
            if (prep_special_i) begin
              cnt_q <= '0;
            end else begin
              cnt_q <= op_is_word(prep_op_i) ? CNT_W'(WORD_W) : CNT_W'(XLEN);
            end
          end
        end
        RUN: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= DONE;  // last bit this cycle
          end
        end
        DONE: begin
          if (core_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rq_q                  <= {{XLEN{1'b0}}, prep_dividend_i};
      dvs_q                 <= prep_divisor_i;
      core_op_o             <= prep_op_i;
      core_neg_q_o          <= prep_neg_q_i;
      core_neg_r_o          <= prep_neg_r_i;
      core_special_o        <= prep_special_i;
      core_special_result_o <= prep_special_result_i;
    end else if (state_q == RUN) begin
      rq_q <= {(q_bit ? diff[XLEN-1:0] : part[XLEN-1:0]), rq_q[XLEN-2:0], q_bit};
    end
  end

  assign core_valid_o     = (state_q == DONE);
  assign core_quotient_o  = rq_q[XLEN-1:0];
  assign core_remainder_o = rq_q[2*XLEN-1:XLEN];

  a_cnt_range: assert property (@(posedge clk) disable iff (rst_n)
    cnt_q <= CNT_W'(XLEN))
    else $error("iteration counter above 64");

  // result offered only once all bits are in
  a_valid_done: assert property (@(posedge clk) disable iff (rst_n)
    core_valid_o |-> cnt_q == '0)
    else $error("core result offered before iteration finished");

endmodule

// ==== div_unit.f ====
+incdir+sim
common/div_pkg.sv
src/div_operand_prep.sv
div_core/div_restoring_core.sv
src/div_result_fixup.sv
src/div_unit.sv
sim/div_unit_tb.sv

// ==== sim/div_model.svh ====
// ========================================
// reference model for the divide unit
// gives the architectural RISC-V result of one operation
// include after importing div_pkg
// ========================================
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

function automatic logic [XLEN-1:0] div_model(input div_op_e op,
                                             input logic [XLEN-1:0] a,
                                             input logic [XLEN-1:0] b);
  logic signed [XLEN-1:0]   sa;
  logic signed [XLEN-1:0]   sb;
  logic [WORD_W-1:0]        ua32;
  logic [WORD_W-1:0]        ub32;
  logic signed [WORD_W-1:0] sa32;
  logic signed [WORD_W-1:0] sb32;
  logic [WORD_W-1:0]        r32;
  logic                     ovf64;
  logic                     ovf32;
  sa    = a;
  sb    = b;
  ua32  = a[WORD_W-1:0];
  ub32  = b[WORD_W-1:0];
  sa32  = a[WORD_W-1:0];
  sb32  = b[WORD_W-1:0];
  ovf64 = (a == {1'b1, {(XLEN-1){1'b0}}}) && (&b);
  ovf32 = (ua32 == {1'b1, {(WORD_W-1){1'b0}}}) && (&ub32);
  r32   = '0;
  case (op)
    OP_DIV:  return (b == '0) ? '1 : (ovf64 ? a : XLEN'(sa / sb));
    OP_DIVU: return (b == '0) ? '1 : a / b;
    OP_REM:  return (b == '0) ? a : (ovf64 ? '0 : XLEN'(sa % sb));
    OP_REMU: return (b == '0) ? a : a % b;
    OP_DIVW: begin
      if (ub32 == '0) return '1;
      r32 = ovf32 ? ua32 : WORD_W'(sa32 / sb32);
    end
    OP_DIVUW: begin
      if (ub32 == '0) return '1;
      r32 = ua32 / ub32;
    end
    OP_REMW: begin
      r32 = (ub32 == '0) ? ua32 : (ovf32 ? '0 : WORD_W'(sa32 % sb32));
    end
    OP_REMUW: begin
      r32 = (ub32 == '0) ? ua32 : ua32 % ub32;
    end
    default: r32 = '0;
  endcase
  return {{(XLEN-WORD_W){r32[WORD_W-1]}}, r32};  // word result, bit 31 copied up
endfunction

`endif

// ==== sim/div_unit_tb.sv ====
`timescale 1ns/1ns
// ========================================
// testbench for the divide unit
// corner and random operands under random back-pressure,
// results checked in order against the reference model
// ========================================
module div_unit_tb
  import div_pkg::*;
();

`include "div_model.svh"

  localparam int TIMEOUT = 200;  // cycles per wait
  localparam logic [XLEN-1:0] MIN_DWORD = {1'b1, {(XLEN-1){1'b0}}};

  logic            clk = 1'b0;
  logic            rst_n;
  logic            in_valid;
  logic            in_ready;
  div_op_e         in_op;
  logic [XLEN-1:0] in_dividend;
  logic [XLEN-1:0] in_divisor;
  logic            out_valid;
  logic            out_ready;
  logic [XLEN-1:0] out_result;

  logic [XLEN-1:0] exp_q[$];           // expected results, oldest first
  int              value_errs  = 0;
  int              other_errs  = 0;
  int              n_in        = 0;
  int              n_out       = 0;
  int              ready_mode  = 0;    // 0 low, 1 random, 2 high
  logic            hold_seen   = 1'b0;
  logic [XLEN-1:0] held_result = '0;

  div_unit i_div_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_valid_i    (in_valid),
    .in_ready_o    (in_ready),
    .in_op_i       (in_op),
    .in_dividend_i (in_dividend),
    .in_divisor_i  (in_divisor),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .out_result_o  (out_result)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // ========================================
  // helpers
  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("%0t: gave up after %0d cycles %s", $time, TIMEOUT, what);
    $display("Done: errors found");
    $finish;
  endtask

  // biased toward values that hit the special cases
  function automatic logic [XLEN-1:0] pick_operand();
    logic [XLEN-1:0] v;
    v = {$urandom(), $urandom()};
    case ($urandom_range(9))
      0: v = '0;
      1: v = '1;
      2: v = MIN_DWORD;
      3: v[WORD_W-1:0] = 32'h8000_0000;  // most negative word, junk above
      4: v[WORD_W-1:0] = '1;
      5: v[WORD_W-1:0] = '0;
      6: v = XLEN'($urandom_range(255));
      default: ;
    endcase
    return v;
  endfunction

  task automatic wait_accept();
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!in_ready && waited < TIMEOUT);
    if (!in_ready) timeout_abort("waiting for in_ready_o");
  endtask

  task automatic send_op(input div_op_e op, input logic [XLEN-1:0] a,
                         input logic [XLEN-1:0] b);
    in_valid    <= 1'b1;
    in_op       <= op;
    in_dividend <= a;
    in_divisor  <= b;
    wait_accept();
  endtask

  // restarts its timeout each time a result leaves
  task automatic drain_results();
    int waited;
    int last_size;
    waited     = 0;
    last_size  = exp_q.size();
    in_valid   <= 1'b0;
    ready_mode <= 2;
    while (exp_q.size() != 0 && waited < TIMEOUT) begin
      @(posedge clk);
      if (exp_q.size() != last_size) begin
        last_size = exp_q.size();
        waited    = 0;
      end else begin
        waited++;
      end
    end
    if (exp_q.size() != 0) timeout_abort("waiting for pending results");
  endtask

  // ========================================
  // consumer ready and scoreboard
  always @(posedge clk) begin
    if (ready_mode == 1) begin
      out_ready <= ($urandom_range(3) != 0);
    end else begin
      out_ready <= (ready_mode == 2);
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      if (in_valid && in_ready) begin
        exp_q.push_back(div_model(in_op, in_dividend, in_divisor));
        n_in++;
      end
      if (hold_seen) begin  // stalled last cycle
        check_value("out_valid_o", XLEN'(out_valid), XLEN'(1));
        check_value("out_result_o (held)", out_result, held_result);
      end
      if (out_valid && out_ready) begin
        n_out++;
        if (exp_q.size() == 0) begin
          $display("%0t: a result came out with no operation pending", $time);
          other_errs++;
        end else begin
          check_value("out_result_o", out_result, exp_q.pop_front());
        end
      end
      hold_seen   = out_valid && !out_ready;
      held_result = out_result;
    end
  end

  // ========================================
  // stimulus
  initial begin
    int i;
    int k;
    void'($urandom(97));
    rst_n       = 1'b1;  // reset is high active
    in_valid    = 1'b0;
    in_op       = OP_DIV;
    in_dividend = '0;
    in_divisor  = '0;
    out_ready   = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b0;
    @(posedge clk);
    check_value("out_valid_o", XLEN'(out_valid), '0);
    check_value("in_ready_o", XLEN'(in_ready), XLEN'(1));

    // special values for every op, both widths
    ready_mode <= 1;
    for (i = 0; i < 8; i++) begin
      send_op(div_op_e'(i), MIN_DWORD, '1);
      send_op(div_op_e'(i), pick_operand(), '0);
      send_op(div_op_e'(i), {$urandom(), 32'h8000_0000}, {$urandom(), 32'hffff_ffff});
      send_op(div_op_e'(i), pick_operand(), {$urandom(), 32'h0});
    end
    for (i = 0; i < 400; i++) begin
      send_op(div_op_e'($urandom_range(7)), pick_operand(), pick_operand());
    end
    drain_results();

    // fill all three stages with the consumer stalled
    ready_mode <= 0;
    for (i = 0; i < 3; i++) begin
      send_op(div_op_e'($urandom_range(7)), pick_operand(), pick_operand());
    end
    in_op       <= div_op_e'($urandom_range(7));
    in_dividend <= pick_operand();
    in_divisor  <= pick_operand();
    for (k = 0; k < 100; k++) begin
      @(posedge clk);
      check_value("in_ready_o", XLEN'(in_ready), '0);
    end
    ready_mode <= 2;
    wait_accept();
    drain_results();
    check_value("result count", XLEN'(n_out), XLEN'(n_in));

    $display("value errors: %0d, other errors: %0d, operations in: %0d, out: %0d",
             value_errs, other_errs, n_in, n_out);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src/div_operand_prep.sv ====
`timescale 1ns/1ns
// ========================================
// input side of the divide unit
// takes one operation, records signs, forms magnitudes
// and settles divide by zero and signed overflow up front
// ========================================
module div_operand_prep
  import div_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  div_op_e         in_op_i,
  input  logic [XLEN-1:0] in_dividend_i,
  input  logic [XLEN-1:0] in_divisor_i,
  output logic            prep_valid_o,
  input  logic            prep_ready_i,
  output div_op_e         prep_op_o,
  output logic [XLEN-1:0] prep_dividend_o,
  output logic [XLEN-1:0] prep_divisor_o,
  output logic            prep_neg_q_o,
  output logic            prep_neg_r_o,
  output logic            prep_special_o,
  output logic [XLEN-1:0] prep_special_result_o
);

  localparam logic [XLEN-1:0]   MIN_DWORD = {1'b1, {(XLEN-1){1'b0}}};
  localparam logic [WORD_W-1:0] MIN_WORD  = {1'b1, {(WORD_W-1){1'b0}}};

  logic            is_word;
  logic            is_signed;
  logic            is_rem;
  logic [XLEN-1:0] a_sx;       // dividend, word sign-extended
  logic [XLEN-1:0] b_sx;
  logic [XLEN-1:0] a_ext;      // dividend as the op sees it
  logic [XLEN-1:0] b_ext;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] a_abs;
  logic [XLEN-1:0] b_abs;
  logic            div_zero;
  logic            overflow;
  logic [XLEN-1:0] spec_res;
  logic            accept;

  // ========================================
  // operand preparation
  assign is_word   = op_is_word(in_op_i);
  assign is_signed = !op_is_unsigned(in_op_i);
  assign is_rem    = op_is_rem(in_op_i);

  assign a_sx = is_word ? sext_word(in_dividend_i) : in_dividend_i;
  assign b_sx = is_word ? sext_word(in_divisor_i) : in_divisor_i;

  always_comb begin
    if (is_signed) begin
      a_ext = a_sx;
      b_ext = b_sx;
    end else if (is_word) begin
      a_ext = {{(XLEN-WORD_W){1'b0}}, in_dividend_i[WORD_W-1:0]};  // zero-extend
      b_ext = {{(XLEN-WORD_W){1'b0}}, in_divisor_i[WORD_W-1:0]};
    end else begin
      a_ext = in_dividend_i;
      b_ext = in_divisor_i;
    end
  end

  assign a_neg = is_signed && a_ext[XLEN-1];
  assign b_neg = is_signed && b_ext[XLEN-1];
  assign a_abs = a_neg ? (~a_ext + 1'b1) : a_ext;
  assign b_abs = b_neg ? (~b_ext + 1'b1) : b_ext;

  // ========================================
  // special cases, word ops look at the low word only
  assign div_zero = is_word ? (in_divisor_i[WORD_W-1:0] == '0) : (in_divisor_i == '0);

  assign overflow = is_signed && !div_zero &&
                    (is_word ? (in_dividend_i[WORD_W-1:0] == MIN_WORD &&
                                &in_divisor_i[WORD_W-1:0])
                             : (in_dividend_i == MIN_DWORD && &in_divisor_i));

  always_comb begin
    if (div_zero) begin
      spec_res = is_rem ? a_sx : '1;  // rem keeps dividend, quot all ones
    end else begin
      spec_res = is_rem ? '0 : a_sx;  // overflow
    end
  end

  // ========================================
  // register stage
  assign in_ready_o = !prep_valid_o || prep_ready_i;  // empty or draining
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      prep_valid_o <= 1'b0;
    end else if (accept) begin
      prep_valid_o <= 1'b1;
    end else if (prep_ready_i) begin
      prep_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      prep_op_o             <= in_op_i;
      // word dividend goes to the top of the low half
      prep_dividend_o       <= is_word ? {a_abs[WORD_W-1:0], {(XLEN-WORD_W){1'b0}}} : a_abs;
      prep_divisor_o        <= is_word ? {{(XLEN-WORD_W){1'b0}}, b_abs[WORD_W-1:0]} : b_abs;
      prep_neg_q_o          <= a_neg ^ b_neg;
      prep_neg_r_o          <= a_neg;
      prep_special_o        <= div_zero || overflow;
      prep_special_result_o <= spec_res;
    end
  end

  // held operation must not move before the core takes it
  a_prep_hold: assert property (@(posedge clk) disable iff (rst_n)
    prep_valid_o && !prep_ready_i |=>
      prep_valid_o && $stable(prep_op_o) && $stable(prep_dividend_o) &&
      $stable(prep_divisor_o) && $stable(prep_neg_q_o) && $stable(prep_neg_r_o) &&
      $stable(prep_special_o) && $stable(prep_special_result_o))
    else $error("prep output changed while stalled");

endmodule

// ==== src/div_result_fixup.sv ====
`timescale 1ns/1ns
// ========================================
// output side of the divide unit
// picks quotient or remainder, restores the sign,
// sign-extends word results and holds them for the consumer
// ========================================
module div_result_fixup
  import div_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            core_valid_i,
  output logic            core_ready_o,
  input  div_op_e         core_op_i,
  input  logic [XLEN-1:0] core_quotient_i,
  input  logic [XLEN-1:0] core_remainder_i,
  input  logic            core_neg_q_i,
  input  logic            core_neg_r_i,
  input  logic            core_special_i,
  input  logic [XLEN-1:0] core_special_result_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output logic [XLEN-1:0] out_result_o
);

  logic            is_rem;
  logic [XLEN-1:0] sel;
  logic            neg;
  logic [XLEN-1:0] signed_val;
  logic [XLEN-1:0] fixed;
  logic [XLEN-1:0] result_d;
  logic            take;

  // ========================================
  // result selection
  assign is_rem = op_is_rem(core_op_i);
  assign sel    = is_rem ? core_remainder_i : core_quotient_i;
  assign neg    = is_rem ? core_neg_r_i : core_neg_q_i;

  assign signed_val = neg ? (~sel + 1'b1) : sel;  // back to two's complement

  // unsigned word results sign-extend too
  assign fixed = op_is_word(core_op_i) ? sext_word(signed_val) : signed_val;

  assign result_d = core_special_i ? core_special_result_i : fixed;

  // ========================================
  // output register
  assign core_ready_o = !out_valid_o || out_ready_i;
  assign take         = core_valid_i && core_ready_o;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      out_valid_o <= 1'b0;
    end else if (take) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;  // consumer took it
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_result_o <= result_d;
    end
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rst_n)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o))
    else $error("result dropped or changed before transfer");

endmodule

// ==== src/div_unit.sv ====
`timescale 1ns/1ns
// ========================================
// top level of the iterative divide unit
// operand prep, restoring core and result fixup in a row
// valid/ready on both sides, results leave in order
// ========================================
module div_unit
  import div_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid_i,
  output logic            in_ready_o,
  input  div_op_e         in_op_i,
  input  logic [XLEN-1:0] in_dividend_i,
  input  logic [XLEN-1:0] in_divisor_i,
  output logic            out_valid_o,
  input  logic            out_ready_i,
  output logic [XLEN-1:0] out_result_o
);

  // prep to core
  logic            prep_valid;
  logic            prep_ready;
  div_op_e         prep_op;
  logic [XLEN-1:0] prep_dividend;
  logic [XLEN-1:0] prep_divisor;
  logic            prep_neg_q;
  logic            prep_neg_r;
  logic            prep_special;
  logic [XLEN-1:0] prep_special_result;

  // core to fixup
  logic            core_valid;
  logic            core_ready;
  div_op_e         core_op;
  logic [XLEN-1:0] core_quotient;
  logic [XLEN-1:0] core_remainder;
  logic            core_neg_q;
  logic            core_neg_r;
  logic            core_special;
  logic [XLEN-1:0] core_special_result;

  div_operand_prep i_prep (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .in_valid_i            (in_valid_i),
    .in_ready_o            (in_ready_o),
    .in_op_i               (in_op_i),
    .in_dividend_i         (in_dividend_i),
    .in_divisor_i          (in_divisor_i),
    .prep_valid_o          (prep_valid),
    .prep_ready_i          (prep_ready),
    .prep_op_o             (prep_op),
    .prep_dividend_o       (prep_dividend),
    .prep_divisor_o        (prep_divisor),
    .prep_neg_q_o          (prep_neg_q),
    .prep_neg_r_o          (prep_neg_r),
    .prep_special_o        (prep_special),
    .prep_special_result_o (prep_special_result)
  );

  div_restoring_core i_core (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .prep_valid_i          (prep_valid),
    .prep_ready_o          (prep_ready),
    .prep_op_i             (prep_op),
    .prep_dividend_i       (prep_dividend),
    .prep_divisor_i        (prep_divisor),
    .prep_neg_q_i          (prep_neg_q),
    .prep_neg_r_i          (prep_neg_r),
    .prep_special_i        (prep_special),
    .prep_special_result_i (prep_special_result),
    .core_valid_o          (core_valid),
    .core_ready_i          (core_ready),
    .core_op_o             (core_op),
    .core_quotient_o       (core_quotient),
    .core_remainder_o      (core_remainder),
    .core_neg_q_o          (core_neg_q),
    .core_neg_r_o          (core_neg_r),
    .core_special_o        (core_special),
    .core_special_result_o (core_special_result)
  );

  div_result_fixup i_fixup (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .core_valid_i          (core_valid),
    .core_ready_o          (core_ready),
    .core_op_i             (core_op),
    .core_quotient_i       (core_quotient),
    .core_remainder_i      (core_remainder),
    .core_neg_q_i          (core_neg_q),
    .core_neg_r_i          (core_neg_r),
    .core_special_i        (core_special),
    .core_special_result_i (core_special_result),
    .out_valid_o           (out_valid_o),
    .out_ready_i           (out_ready_i),
    .out_result_o          (out_result_o)
  );

endmodule
